// File: sim.f
common/video_pkg.sv
common/star_pkg.sv
src/video_timing.sv
stars/star_regs.sv
stars/star_lfsr.sv
stars/star_field.sv
src/star_video_top.sv
testbench/clk_gen.sv
testbench/star_chk.sv
testbench/star_tb.sv

// File: Makefile
SRCS := $(shell cat sim.f)

.PHONY: run clean

obj_dir/Vstar_tb: sim.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module star_tb -f sim.f

run: obj_dir/Vstar_tb
	./obj_dir/Vstar_tb > sim.log 2>&1; cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: testbench/star_tb.sv
`default_nettype none
`timescale 1ns/1ps

module star_tb;

    // Five frames of clocks, with some margin.
    localparam int TIMEOUT_CYCLES =
        5 * video_pkg::H_TOTAL * video_pkg::V_TOTAL * video_pkg::CEN_DIV + 400;

    logic clk;
    logic rst_n;
    logic wr_valid;
    star_pkg::reg_addr_t wr_addr;
    star_pkg::scroll_t wr_data;
    logic credit;
    logic hb;
    logic vb;
    video_pkg::pxl_t hdump;
    video_pkg::line_t vdump;
    video_pkg::star_pix_t star0;
    video_pkg::star_pix_t star1;

    int cycles = 0;
    int edge_cnt = 0;
    int err_star = 0;
    int err_credit = 0;
    int err_timing = 0;
    int writes_issued = 0;
    int credits_seen = 0;
    int retired = 0;
    int rises = 0;
    int seed;

    // Model state: scroll registers, write queue, one shift register per layer.
    star_pkg::scroll_t m_reg [4] = '{default: '0};
    star_pkg::reg_addr_t q_addr [$];
    star_pkg::scroll_t q_data [$];
    star_pkg::poly_t m_poly [2];
    video_pkg::pxl_t m_skip [2];
    logic m_last = 1'b0;

    clk_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    star_video_top UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_valid (wr_valid),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .credit   (credit),
        .hdump    (hdump),
        .vdump    (vdump),
        .hb       (hb),
        .vb       (vb),
        .star0    (star0),
        .star1    (star1)
    );

    bind star_video_top star_chk u_chk (
        .clk      (clk),
        .rst_n    (rst_n),
        .vb       (vb),
        .wr_valid (wr_valid),
        .credit   (credit),
        .star0    (star0),
        .star1    (star1)
    );

    // Seed: layer pattern mixed with sum bits, the rotated sum, then the fill.
    function automatic star_pkg::poly_t seed_of(input logic layer,
                                                input video_pkg::line_t vpos,
                                                input video_pkg::line_t line);
        video_pkg::line_t s;
        logic [3:0] pattern;
        logic [9:0] fill;
        s = vpos + line;
        pattern = layer ? 4'b1001 : 4'b0110;
        fill = layer ? ~star_pkg::POLY_FILL : star_pkg::POLY_FILL;
        return {pattern ^ {s[3], s[2], s[7], s[6]}, s[3:0], s[8:4], fill};
    endfunction

    // Expected pixel: colour only when the whole brightness window is set.
    function automatic video_pkg::star_pix_t expected_star(input star_pkg::poly_t p);
        logic bright;
        bright = 1'b1;
        for (int i = star_pkg::BRIGHT_LO; i <= star_pkg::BRIGHT_HI; i++) begin
            if (!p[i]) bright = 1'b0;
        end
        return {2'b00, p[6:4], bright ? p[3:0] : 4'hf};
    endfunction

    function automatic int credits_avail();
        return star_pkg::WQ_DEPTH - writes_issued + credits_seen;
    endfunction

    task automatic check_star(input int layer, input video_pkg::star_pix_t got,
                              input video_pkg::star_pix_t exp);
        if (got !== exp) begin
            err_star++;
            $display("error at %0t: star%0d is %h, model gives %h", $time, layer, got, exp);
        end
    endtask

    task automatic check_credit(input int got, input int exp);
        if (got != exp) begin
            err_credit++;
            $display("error at %0t: credit count %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_timing(input video_pkg::pxl_t hd, input video_pkg::line_t vd,
                                input logic hbv, input logic vbv,
                                input video_pkg::pxl_t ehd, input video_pkg::line_t evd,
                                input logic ehb, input logic evb);
        if ({hd, vd, hbv, vbv} !== {ehd, evd, ehb, evb}) begin
            err_timing++;
            $display("error at %0t: timing h%0d v%0d hb%b vb%b, expected h%0d v%0d hb%b vb%b",
                     $time, hd, vd, hbv, vbv, ehd, evd, ehb, evb);
        end
    endtask

    // Clock count since reset, plus the run limit.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (rst_n) edge_cnt <= edge_cnt + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Compare at mid cycle, then advance the model to the next edge.
    always @(negedge clk) begin
        int pix;
        video_pkg::pxl_t m_hd;
        video_pkg::line_t m_vd;
        logic m_hb;
        logic m_vb;
        logic m_cen;
        logic load;
        video_pkg::pxl_t hp;
        video_pkg::line_t vp;
        star_pkg::reg_addr_t a;
        star_pkg::scroll_t d;
        // Counters and blanking from the clock count.
        pix = (edge_cnt >= 1) ? (edge_cnt - 1) / video_pkg::CEN_DIV : 0;
        m_hd = video_pkg::pxl_t'(pix % video_pkg::H_TOTAL);
        m_vd = video_pkg::line_t'((pix / video_pkg::H_TOTAL) % video_pkg::V_TOTAL);
        m_hb = int'(m_hd) >= video_pkg::H_ACTIVE;
        m_vb = int'(m_vd) >= video_pkg::V_ACTIVE;
        m_cen = (edge_cnt >= 1) &&
                ((edge_cnt - 1) % video_pkg::CEN_DIV == video_pkg::CEN_DIV - 1);
        check_timing(hdump, vdump, hb, vb, m_hd, m_vd, m_hb, m_vb);
        if (credit === 1'b1) credits_seen++;
        check_credit(credits_seen, retired);
        // Shift registers are defined from the first load onward.
        if (rises >= 2) begin
            check_star(0, star0, expected_star(m_poly[0]));
            check_star(1, star1, expected_star(m_poly[1]));
        end
        // Layers see the scroll values from before this edge.
        load = m_hb | m_vb;
        for (int l = 0; l < 2; l++) begin
            hp = m_reg[2 * l][8:0];
            vp = m_reg[2 * l + 1][8:0];
            if (load && !m_last) begin
                m_poly[l] = seed_of(1'(l), vp, m_vd);
                m_skip[l] = hp;
            end else if (load ? (m_skip[l] != 0) : m_cen) begin
                if (m_skip[l] != 0) m_skip[l] = m_skip[l] - 1'b1;
                m_poly[l] = {m_poly[l][21:0], m_poly[l][21] == m_poly[l][17]};
            end
        end
        if (load && !m_last) rises++;
        m_last = load;
        // One queued write applied per clock in vertical blank.
        if (m_vb && q_addr.size() != 0) begin
            a = q_addr.pop_front();
            d = q_data.pop_front();
            if (int'(a) < 4) m_reg[a] = d;
            retired++;
        end
        if (rst_n && wr_valid === 1'b1) begin
            q_addr.push_back(wr_addr);
            q_data.push_back(wr_data);
        end
    end

    task automatic wait_vb(input logic level);
        @(negedge clk);
        while (vb !== level) @(negedge clk);
    endtask

    task automatic wait_line(input int line);
        @(negedge clk);
        while (int'(vdump) != line) @(negedge clk);
    endtask

    // One write cycle, once a credit is held.
    task automatic write_reg(input star_pkg::reg_addr_t addr, input star_pkg::scroll_t data);
        while (credits_avail() == 0) @(negedge clk);
        @(posedge clk);
        #1;
        wr_valid = 1'b1;
        wr_addr = addr;
        wr_data = data;
        writes_issued++;
    endtask

    task automatic bus_idle();
        @(posedge clk);
        #1;
        wr_valid = 1'b0;
    endtask

    initial begin
        seed = 16;
        wr_valid = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        // Frame 0 and frame 1 run with zero scroll.
        wait_vb(1'b1);
        wait_vb(1'b0);
        // New scroll in active video, two writes back to back.
        wait_line(4);
        write_reg(star_pkg::ADDR_VPOS0, star_pkg::scroll_t'($random(seed)));
        write_reg(star_pkg::ADDR_HPOS1, star_pkg::scroll_t'($random(seed)));
        bus_idle();
        check_credit(credits_avail(), 0);
        // Both credits come back in the next blank.
        wait_vb(1'b1);
        while (credits_avail() != star_pkg::WQ_DEPTH) @(negedge clk);
        // Third write, then one to an unused address.
        wait_vb(1'b0);
        wait_line(4);
        write_reg(star_pkg::ADDR_HPOS0, star_pkg::scroll_t'($random(seed)));
        write_reg(star_pkg::reg_addr_t'(5), star_pkg::scroll_t'($random(seed)));
        bus_idle();
        // Whole frame with the new values.
        wait_vb(1'b1);
        wait_vb(1'b0);
        wait_vb(1'b1);
        while (credits_avail() != star_pkg::WQ_DEPTH) @(negedge clk);
        repeat (8) @(negedge clk);
        $display("errors: star %0d, credit %0d, timing %0d, checker %0d",
                 err_star, err_credit, err_timing, UUT.u_chk.fails);
        if (err_star + err_credit + err_timing + UUT.u_chk.fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/star_chk.sv
`default_nettype none
`timescale 1ns/1ps

module star_chk (
    input wire                       clk,
    input wire                       rst_n,
    input wire                       vb,
    input wire                       wr_valid,
    input wire                       credit,
    input wire video_pkg::star_pix_t star0,
    input wire video_pkg::star_pix_t star1
);

    int unsigned writes;
    int unsigned returns;

    // Number of failed assertions.
    int unsigned fails = 0;

    // Writes accepted and credits handed back since reset.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            writes  <= 0;
            returns <= 0;
        end else begin
            if (wr_valid) begin
                writes <= writes + 1;
            end
            if (credit) begin
                returns <= returns + 1;
            end
        end
    end

    // Each credit pays back a write that was already made.
    credit_after_write: assert property (@(posedge clk) disable iff (!rst_n)
        credit |-> returns < writes)
        else begin
            fails++;
            $error("credit returned with no outstanding write");
        end

    // Credits only follow a clock spent in vertical blank.
    credit_in_blank: assert property (@(posedge clk) disable iff (!rst_n)
        credit |-> $past(vb))
        else begin
            fails++;
            $error("credit pulse outside vertical blank");
        end

    // Top two pixel bits are unused.
    star_top_bits: assert property (@(posedge clk) disable iff (!rst_n)
        star0[8:7] == 2'b00 && star1[8:7] == 2'b00)
        else begin
            fails++;
            $error("star pixel bits 8:7 not zero");
        end

endmodule

`default_nettype wire

// File: testbench/clk_gen.sv
`default_nettype none
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period.
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held for eight rising edges, released just after the last one.
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: src/star_video_top.sv
`default_nettype none
`timescale 1ns/1ps

module star_video_top (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      wr_valid,
    input  wire star_pkg::reg_addr_t wr_addr,
    input  wire star_pkg::scroll_t   wr_data,
    output logic                     credit,
    output video_pkg::pxl_t          hdump,
    output video_pkg::line_t         vdump,
    output logic                     hb,
    output logic                     vb,
    output video_pkg::star_pix_t     star0,
    output video_pkg::star_pix_t     star1
);

    logic              pxl_cen;
    star_pkg::scroll_t hpos0;
    star_pkg::scroll_t vpos0;
    star_pkg::scroll_t hpos1;
    star_pkg::scroll_t vpos1;

    // Pixel enable, counters and blanking.
    video_timing u_timing (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .hdump   (hdump),
        .vdump   (vdump),
        .hb      (hb),
        .vb      (vb)
    );

    // Host scroll registers, updated in vertical blank.
    star_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .vb       (vb),
        .wr_valid (wr_valid),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .credit   (credit),
        .hpos0    (hpos0),
        .vpos0    (vpos0),
        .hpos1    (hpos1),
        .vpos1    (vpos1)
    );

    // Both star layers.
    star_field u_stars (
        .clk     (clk),
        .pxl_cen (pxl_cen),
        .hb      (hb),
        .vb      (vb),
        .vdump   (vdump),
        .hpos0   (hpos0),
        .vpos0   (vpos0),
        .hpos1   (hpos1),
        .vpos1   (vpos1),
        .star0   (star0),
        .star1   (star1)
    );

endmodule

`default_nettype wire

// File: stars/star_field.sv
`default_nettype none
`timescale 1ns/1ps

module star_field (
    input  wire                   clk,
    input  wire                   pxl_cen,
    input  wire                   hb,
    input  wire                   vb,
    input  wire video_pkg::line_t vdump,
    input  wire star_pkg::scroll_t hpos0,
    input  wire star_pkg::scroll_t vpos0,
    input  wire star_pkg::scroll_t hpos1,
    input  wire star_pkg::scroll_t vpos1,
    output video_pkg::star_pix_t  star0,
    output video_pkg::star_pix_t  star1
);

    logic            load;
    star_pkg::poly_t poly0;
    star_pkg::poly_t poly1;

    // Brightness window check and pixel packing.
    // Outside the window the colour is all ones, so the pixel is transparent.
    function automatic video_pkg::star_pix_t star_decode(input star_pkg::poly_t p);
        logic bright;
        bright = &p[star_pkg::BRIGHT_HI:star_pkg::BRIGHT_LO];
        return {2'b00, p[6:4], bright ? p[3:0] : 4'hf};
    endfunction

    // Generators reseed at the start of any blanking.
    assign load = hb | vb;

    star_lfsr u_lfsr0 (
        .clk     (clk),
        .pxl_cen (pxl_cen),
        .load    (load),
        .layer   (1'b0),
        .hpos    (hpos0[8:0]),
        .vpos    (vpos0[8:0]),
        .vdump   (vdump),
        .poly    (poly0)
    );

    star_lfsr u_lfsr1 (
        .clk     (clk),
        .pxl_cen (pxl_cen),
        .load    (load),
        .layer   (1'b1),
        .hpos    (hpos1[8:0]),
        .vpos    (vpos1[8:0]),
        .vdump   (vdump),
        .poly    (poly1)
    );

    assign star0 = star_decode(poly0);
    assign star1 = star_decode(poly1);

endmodule

`default_nettype wire

// File: stars/star_lfsr.sv
`default_nettype none
`timescale 1ns/1ps

module star_lfsr (
    input  wire                   clk,
    input  wire                   pxl_cen,
    input  wire                   load,
    input  wire                   layer,
    input  wire video_pkg::pxl_t  hpos,
    input  wire video_pkg::line_t vpos,
    input  wire video_pkg::line_t vdump,
    output star_pkg::poly_t       poly
);

    logic             load_last;
    logic             load_rise;
    logic             skip_left;
    logic             step;
    video_pkg::pxl_t  skip_cnt;
    video_pkg::line_t v_sum;
    star_pkg::poly_t  seed;

    // Vertical scroll plus current line.
    assign v_sum = vpos + vdump;

    // Seed: layer pattern mixed with sum bits, the sum rotated, then the fill.
    // Layer 1 gets the fill inverted so both layers differ.
    assign seed = {{layer, ~layer, ~layer, layer} ^ {v_sum[3:2], v_sum[7:6]},
                   v_sum[3:0],
                   v_sum[8:4],
                   star_pkg::POLY_FILL ^ {10{layer}}};

    assign load_rise = load && !load_last;
    assign skip_left = skip_cnt != '0;

    // In blank, run free until the horizontal skip is used up.
    // In active video, one step per pixel.
    assign step = load ? skip_left : pxl_cen;

    always_ff @(posedge clk) begin
        load_last <= load;
        if (load_rise) begin
            poly     <= seed;
            skip_cnt <= hpos;
        end else if (step) begin
            if (skip_left) begin
                skip_cnt <= skip_cnt - 1'b1;
            end
            // Inverted feedback from taps 21 and 17.
            poly <= {poly[21:0], ~(poly[21] ^ poly[17])};
        end
    end

endmodule

`default_nettype wire

// File: stars/star_regs.sv
`default_nettype none
`timescale 1ns/1ps

module star_regs (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      vb,
    input  wire                      wr_valid,
    input  wire star_pkg::reg_addr_t wr_addr,
    input  wire star_pkg::scroll_t   wr_data,
    output logic                     credit,
    output star_pkg::scroll_t        hpos0,
    output star_pkg::scroll_t        vpos0,
    output star_pkg::scroll_t        hpos1,
    output star_pkg::scroll_t        vpos1
);

    star_pkg::reg_addr_t           q_addr [star_pkg::WQ_DEPTH];
    star_pkg::scroll_t             q_data [star_pkg::WQ_DEPTH];
    logic [star_pkg::WQ_PTR_W-1:0] wr_ptr;
    logic [star_pkg::WQ_PTR_W-1:0] rd_ptr;
    logic [star_pkg::WQ_CNT_W-1:0] count;
    logic                          retire;

    // Circular pointer step.
    function automatic logic [star_pkg::WQ_PTR_W-1:0] ptr_next(
        input logic [star_pkg::WQ_PTR_W-1:0] p
    );
        return (int'(p) == star_pkg::WQ_DEPTH - 1) ? '0 : p + 1'b1;
    endfunction

    // Drain one entry per clock, only in vertical blank.
    assign retire = vb && (count != '0);

    // Queue storage.
    // The host never writes into a full queue while it obeys the credits.
    always_ff @(posedge clk) begin
        if (wr_valid) begin
            q_addr[wr_ptr] <= wr_addr;
            q_data[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
            hpos0  <= '0;
            vpos0  <= '0;
            hpos1  <= '0;
            vpos1  <= '0;
        end else begin
            // Every retired entry gives one credit back.
            credit <= retire;
            if (wr_valid) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (retire) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // Occupancy.
            case ({wr_valid, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            // Apply the oldest entry, unknown addresses are dropped.
            if (retire) begin
                case (q_addr[rd_ptr])
                    star_pkg::ADDR_HPOS0: hpos0 <= q_data[rd_ptr];
                    star_pkg::ADDR_VPOS0: vpos0 <= q_data[rd_ptr];
                    star_pkg::ADDR_HPOS1: hpos1 <= q_data[rd_ptr];
                    star_pkg::ADDR_VPOS1: vpos1 <= q_data[rd_ptr];
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: src/video_timing.sv
`default_nettype none
`timescale 1ns/1ps

module video_timing (
    input  wire              clk,
    input  wire              rst_n,
    output logic             pxl_cen,
    output video_pkg::pxl_t  hdump,
    output video_pkg::line_t vdump,
    output logic             hb,
    output logic             vb
);

    logic [video_pkg::CEN_W-1:0] cen_cnt;
    logic                        cen_last;
    logic                        h_wrap;
    logic                        v_wrap;
    video_pkg::pxl_t             h_nxt;
    video_pkg::line_t            v_nxt;

    // Last clock of each pixel period.
    assign cen_last = int'(cen_cnt) == video_pkg::CEN_DIV - 1;

    // End of line and end of frame.
    assign h_wrap = int'(hdump) == video_pkg::H_TOTAL - 1;
    assign v_wrap = int'(vdump) == video_pkg::V_TOTAL - 1;

    // Counter values for the next clock.
    // Blanking is decoded from these so it lines up with the counters.
    always_comb begin
        h_nxt = hdump;
        v_nxt = vdump;
        if (pxl_cen) begin
            if (h_wrap) begin
                h_nxt = '0;
                // Line advances only when the pixel counter wraps.
                v_nxt = v_wrap ? '0 : vdump + 1'b1;
            end else begin
                h_nxt = hdump + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cen_cnt <= '0;
            pxl_cen <= 1'b0;
            hdump   <= '0;
            vdump   <= '0;
            hb      <= 1'b0;
            vb      <= 1'b0;
        end else begin
            // Pixel enable, one clock in CEN_DIV.
            cen_cnt <= cen_last ? '0 : cen_cnt + 1'b1;
            pxl_cen <= cen_last;
            hdump   <= h_nxt;
            vdump   <= v_nxt;
            // Registered blanking.
            hb      <= int'(h_nxt) >= video_pkg::H_ACTIVE;
            vb      <= int'(v_nxt) >= video_pkg::V_ACTIVE;
        end
    end

endmodule

`default_nettype wire

// File: common/star_pkg.sv
`default_nettype none

package star_pkg;

    // Star shift register.
    typedef logic [22:0] poly_t;

    // Scroll register as the host writes it, only bits 8:0 matter.
    typedef logic [15:0] scroll_t;

    // Host register address.
    typedef logic [2:0] reg_addr_t;

    // Register map.
    localparam reg_addr_t ADDR_HPOS0 = 3'd0;
    localparam reg_addr_t ADDR_VPOS0 = 3'd1;
    localparam reg_addr_t ADDR_HPOS1 = 3'd2;
    localparam reg_addr_t ADDR_VPOS1 = 3'd3;

    // Write queue entries, equal to the host's starting credits.
    localparam int WQ_DEPTH = 2;
    localparam int WQ_PTR_W = $clog2(WQ_DEPTH);
    localparam int WQ_CNT_W = $clog2(WQ_DEPTH + 1);

    // Fixed low part of the seed.
    localparam logic [9:0] POLY_FILL = 10'h55;

    // Brightness window inside the shift register.
    localparam int BRIGHT_LO = 7;
    localparam int BRIGHT_HI = 15;

endpackage

`default_nettype wire

// File: common/video_pkg.sv
`default_nettype none

package video_pkg;

    // Horizontal pixel position within a line.
    typedef logic [8:0] pxl_t;

    // Line number within a frame.
    typedef logic [8:0] line_t;

    // Star pixel.
    // Bits 8:7 stay zero, 6:4 pick the palette, 3:0 are the colour.
    // A colour of all ones is transparent.
    typedef logic [8:0] star_pix_t;

    // Pixels per line, visible part first.
    localparam int H_TOTAL  = 64;
    localparam int H_ACTIVE = 48;

    // Lines per frame, visible part first.
    localparam int V_TOTAL  = 40;
    localparam int V_ACTIVE = 32;

    // System clocks per pixel.
    localparam int CEN_DIV  = 2;

    // Width of the pixel enable divider.
    localparam int CEN_W    = $clog2(CEN_DIV);

endpackage

`default_nettype wire
